/* flist.f */
verilog/vp_pkg.sv
verilog/vp_cfg_regs.sv
verilog/vp_window_picker.sv
verilog/vp_pingpong_writer.sv
verilog/vp_encoder_top.sv
sim/vp_encoder_props.sv
sim/tb_vp_encoder.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_vp_encoder -f flist.f \
    -Mdir obj_dir -o tb_vp_encoder > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_vp_encoder > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0

/* sim/tb_vp_encoder.sv */
// directed tests; stimulus on the falling edge, outputs sampled in the low phase; stops at first error
module tb_vp_encoder;

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_LISTS   = 20;
    // 40 cycles per scanned entry over every test, plus margin for apb traffic
    localparam int WD_CYCLES    = 40 * (32 + 6 + 24 + 22 + RAND_LISTS * 32) + 2000;

    logic                             clk;
    logic                             rst_n;
    vp_pkg::apb_req_t                 apb_req;
    vp_pkg::apb_rsp_t                 apb_rsp;
    vp_pkg::entry_t                   entries [vp_pkg::NUM_ENTRIES];
    logic signed [vp_pkg::DATA_W-1:0] ia_data [vp_pkg::NUM_CHANNELS];
    vp_pkg::pp_buf_t                  right_buf;
    vp_pkg::pp_buf_t                  left_buf;
    logic                             right_ready;
    logic                             left_ready;

    logic [31:0]     lfsr_state;
    // side 0 is right, 1 is left
    logic            got_side [$];
    vp_pkg::pp_buf_t got_buf [$];
    logic            exp_side [$];
    vp_pkg::pp_buf_t exp_buf [$];

    vp_encoder_top vp_encoder_top_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_apb         (apb_req),
        .o_apb         (apb_rsp),
        .i_entries     (entries),
        .i_ia_data     (ia_data),
        .o_right_buf   (right_buf),
        .o_left_buf    (left_buf),
        .o_right_ready (right_ready),
        .o_left_ready  (left_ready)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_buf(string name, vp_pkg::pp_buf_t got, vp_pkg::pp_buf_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_reg(string name, logic [vp_pkg::APB_DATA_W-1:0] got,
                             logic [vp_pkg::APB_DATA_W-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // one setup plus one access cycle, starts and ends on a falling edge
    task automatic apb_access(logic wr, logic [vp_pkg::APB_ADDR_W-1:0] addr,
                              logic [vp_pkg::APB_DATA_W-1:0] wdata,
                              output logic [vp_pkg::APB_DATA_W-1:0] rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(HALF_PERIOD / 2);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // no wait states ever
        check_bit("pready", apb_rsp.pready, 1'b1);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic reg_write(logic [vp_pkg::APB_ADDR_W-1:0] addr, logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        check_bit("pslverr", err, 1'b0);
    endtask

    task automatic reg_read(logic [vp_pkg::APB_ADDR_W-1:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_bit("pslverr", err, 1'b0);
    endtask

    // poll status until the scan is over
    task automatic wait_idle();
        logic [31:0] rd;
        do begin
            reg_read(vp_pkg::REG_STATUS, rd);
        end while (rd[0]);
    endtask

    // deterministic list, validity from the mask
    task automatic fill_fixed(logic [31:0] mask);
        for (int i = 0; i < vp_pkg::NUM_ENTRIES; i++) begin
            entries[i].valid   = mask[i];
            entries[i].pos     = 3'(i * 5);
            entries[i].addr[0] = 7'(i);
            entries[i].addr[1] = 7'(i + 40);
            entries[i].addr[2] = 7'(127 - i);
            entries[i].weight  = 16'(i * 311 - 4000);
        end
        for (int c = 0; c < vp_pkg::NUM_CHANNELS; c++) begin
            ia_data[c] = 16'(c * 1000 - 3500);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < vp_pkg::NUM_ENTRIES; i++) begin
            entries[i].valid  = 1'(rand_bits(1));
            entries[i].pos    = 3'(rand_bits(3));
            entries[i].addr   = 21'(rand_bits(21));
            entries[i].weight = 16'(rand_bits(16));
        end
        for (int c = 0; c < vp_pkg::NUM_CHANNELS; c++) begin
            ia_data[c] = 16'(rand_bits(16));
        end
    endtask

    // reference scan, walks the list window by window
    task automatic build_expected(int len);
        vp_pkg::pp_buf_t b;
        int              idx;
        int              slot;
        int              hit;
        logic            side;
        exp_side.delete();
        exp_buf.delete();
        b    = '0;
        idx  = 0;
        slot = 0;
        side = 1'b0;
        while (idx < len) begin
            hit = -1;
            for (int k = 0; k < vp_pkg::WINDOW; k++) begin
                if (hit < 0 && idx + k < len && entries[idx + k].valid) hit = k;
            end
            if (hit < 0) begin
                idx += vp_pkg::WINDOW;
            end else begin
                b[slot].addr   = entries[idx + hit].addr;
                b[slot].weight = entries[idx + hit].weight;
                b[slot].act    = ia_data[entries[idx + hit].pos];
                slot++;
                idx += hit + 1;
                if (slot == vp_pkg::SLOTS) begin
                    exp_side.push_back(side);
                    exp_buf.push_back(b);
                    side = ~side;
                    slot = 0;
                    b    = '0;
                end
            end
        end
        // partial buffer, unused slots already zero
        if (slot > 0) begin
            exp_side.push_back(side);
            exp_buf.push_back(b);
        end
    endtask

    task automatic compare_results();
        if (got_buf.size() != exp_buf.size()) begin
            fail_now($sformatf("mismatch at %0t: ready pulse count got %0d expected %0d",
                               $time, got_buf.size(), exp_buf.size()));
        end
        foreach (exp_buf[i]) begin
            check_bit($sformatf("ready side %0d", i), got_side[i], exp_side[i]);
            check_buf($sformatf("buffer %0d", i), got_buf[i], exp_buf[i]);
        end
    endtask

    task automatic run_scan(int len);
        build_expected(len);
        got_side.delete();
        got_buf.delete();
        reg_write(vp_pkg::REG_LEN, 32'(len));
        reg_write(vp_pkg::REG_CTRL, 32'h1);
        wait_idle();
        repeat (2) @(negedge clk);
        compare_results();
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        check_bit("o_right_ready", right_ready, 1'b0);
        check_bit("o_left_ready", left_ready, 1'b0);
        reg_read(vp_pkg::REG_STATUS, rd);
        check_reg("STATUS", rd, 32'h0);
        check_buf("o_right_buf", right_buf, '0);
        check_buf("o_left_buf", left_buf, '0);
    endtask

    task automatic test_regs();
        logic [31:0] rd;
        logic        err;
        reg_write(vp_pkg::REG_LEN, 32'd13);
        reg_read(vp_pkg::REG_LEN, rd);
        check_reg("LEN", rd, 32'd13);
        // unmapped offset errors and writes nothing
        apb_access(1'b1, 4'hC, 32'd7, rd, err);
        check_bit("pslverr", err, 1'b1);
        reg_read(vp_pkg::REG_LEN, rd);
        check_reg("LEN", rd, 32'd13);
        // long all-invalid scan keeps the block busy
        fill_fixed('0);
        got_buf.delete();
        reg_write(vp_pkg::REG_LEN, 32'd32);
        reg_write(vp_pkg::REG_CTRL, 32'h1);
        reg_read(vp_pkg::REG_STATUS, rd);
        check_reg("STATUS", rd, 32'h1);
        reg_write(vp_pkg::REG_LEN, 32'd5);
        reg_write(vp_pkg::REG_CTRL, 32'h1);
        reg_read(vp_pkg::REG_LEN, rd);
        check_reg("LEN", rd, 32'd32);
        wait_idle();
        repeat (3) @(negedge clk);
        // the dropped start must not restart the scan
        reg_read(vp_pkg::REG_STATUS, rd);
        check_reg("STATUS", rd, 32'h0);
        if (got_buf.size() != 0) fail_now("ready pulsed during a scan of invalid entries");
    endtask

    task automatic test_short_lengths();
        int lens [6] = '{1, 2, 3, 4, 5, 7};
        fill_fixed('1);
        foreach (lens[i]) run_scan(lens[i]);
    endtask

    task automatic test_random();
        for (int n = 0; n < RAND_LISTS; n++) begin
            fill_random();
            run_scan(int'(rand_bits(6)) % 33);
        end
    endtask

    // capture each announced buffer during its pulse
    always @(negedge clk) begin
        if (right_ready) begin
            got_side.push_back(1'b0);
            got_buf.push_back(right_buf);
        end
        if (left_ready) begin
            got_side.push_back(1'b1);
            got_buf.push_back(left_buf);
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        lfsr_state = 32'hbbaa_f933;
        rst_n      = 1'b0;
        apb_req    = '0;
        fill_fixed('0);
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_regs();
        // dense list, one right and one left buffer
        fill_fixed(32'h0000_003F);
        run_scan(6);
        // single gaps, double gaps, empty windows
        fill_fixed(32'h00C0_0A45);
        run_scan(24);
        run_scan(0);
        test_short_lengths();
        test_random();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* sim/vp_encoder_props.sv */
// bound into vp_encoder_top; assertions only fire when the simulator enables them
module vp_encoder_props (
    input logic                     i_clk,
    input logic                     i_rst_n,
    input logic                     i_right_ready,
    input logic                     i_left_ready,
    input vp_pkg::apb_req_t         i_apb_req,
    input vp_pkg::apb_rsp_t         i_apb_rsp,
    input logic                     i_start,
    input logic                     i_busy,
    input logic [vp_pkg::IDX_W-1:0] i_len
);

    // one side announced at a time
    readies_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_right_ready && i_left_ready))
        else $error("both ready outputs high in the same cycle");

    // pulses last exactly one cycle
    right_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_right_ready |=> !i_right_ready)
        else $error("right ready held for more than one cycle");

    left_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_left_ready |=> !i_left_ready)
        else $error("left ready held for more than one cycle");

    // a rejected access leaves length and start untouched
    err_no_effect: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_apb_rsp.pslverr |=> ($stable(i_len) && !i_start))
        else $error("apb access with pslverr changed the length or started a scan");

    // scan begins the cycle after the start pulse
    start_then_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start |=> i_busy)
        else $error("busy did not rise in the cycle after the start pulse");

endmodule

bind vp_encoder_top vp_encoder_props vp_encoder_props_i (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_right_ready (o_right_ready),
    .i_left_ready  (o_left_ready),
    .i_apb_req     (i_apb),
    .i_apb_rsp     (o_apb),
    .i_start       (start),
    .i_busy        (busy),
    .i_len         (len)
);

/* verilog/vp_encoder_top.sv */
// entries and activations must stay stable while STATUS shows busy; outputs have no back-pressure
module vp_encoder_top (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  vp_pkg::apb_req_t             i_apb,
    output vp_pkg::apb_rsp_t             o_apb,
    input  vp_pkg::entry_t               i_entries [vp_pkg::NUM_ENTRIES],
    input  logic signed [vp_pkg::DATA_W-1:0] i_ia_data [vp_pkg::NUM_CHANNELS],
    output vp_pkg::pp_buf_t              o_right_buf,
    output vp_pkg::pp_buf_t              o_left_buf,
    output logic                         o_right_ready,
    output logic                         o_left_ready
);

    logic                     start;
    logic                     busy;
    logic [vp_pkg::IDX_W-1:0] len;
    logic [vp_pkg::IDX_W-1:0] idx;
    vp_pkg::pick_t            pick;

    // register block steers the scan
    vp_cfg_regs vp_cfg_regs_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_apb   (i_apb),
        .o_apb   (o_apb),
        .i_busy  (busy),
        .o_start (start),
        .o_len   (len)
    );

    // window selection, pure logic
    vp_window_picker vp_window_picker_i (
        .i_idx     (idx),
        .i_len     (len),
        .i_entries (i_entries),
        .i_ia_data (i_ia_data),
        .o_pick    (pick)
    );

    // fsm plus both output buffers
    vp_pingpong_writer vp_pingpong_writer_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (start),
        .i_pick        (pick),
        .o_idx         (idx),
        .o_busy        (busy),
        .o_right_buf   (o_right_buf),
        .o_left_buf    (o_left_buf),
        .o_right_ready (o_right_ready),
        .o_left_ready  (o_left_ready)
    );

endmodule

/* verilog/vp_pingpong_writer.sv */
// no back-pressure, a buffer must be taken during its ready pulse; start is ignored unless idle
module vp_pingpong_writer (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  vp_pkg::pick_t            i_pick,
    output logic [vp_pkg::IDX_W-1:0] o_idx,
    output logic                     o_busy,
    output vp_pkg::pp_buf_t          o_right_buf,
    output vp_pkg::pp_buf_t          o_left_buf,
    output logic                     o_right_ready,
    output logic                     o_left_ready
);

    localparam logic [1:0] LAST_SLOT = 2'(vp_pkg::SLOTS - 1);

    vp_pkg::wr_state_e        state_q;
    logic [vp_pkg::IDX_W-1:0] idx_q;
    logic [1:0]               slot_cnt_q;
    vp_pkg::pp_buf_t          right_buf_q;
    vp_pkg::pp_buf_t          left_buf_q;
    logic                     right_rdy_q;
    logic                     left_rdy_q;

    vp_pkg::pp_buf_t          cur_buf;
    vp_pkg::pp_buf_t          nxt_buf;
    logic                     active;
    logic                     full;
    logic                     buf_done;

    assign active = (state_q != vp_pkg::WR_IDLE);
    // buffer the state is filling
    assign cur_buf = (state_q == vp_pkg::WR_LEFT) ? left_buf_q : right_buf_q;

    // last slot of a buffer gets written
    assign full     = i_pick.found && (slot_cnt_q == LAST_SLOT);
    // announce on full, or on flush with something in it
    assign buf_done = active && (i_pick.at_end ? (slot_cnt_q != 2'd0) : full);

    // next contents of the current buffer
    always_comb begin
        nxt_buf = cur_buf;
        if (i_pick.at_end) begin
            // zero every unfilled slot, the whole buffer when nothing was written
            for (int s = 0; s < vp_pkg::SLOTS; s++) begin
                if (2'(s) >= slot_cnt_q) begin
                    nxt_buf[s] = '0;
                end
            end
        end else if (i_pick.found) begin
            nxt_buf[slot_cnt_q] = i_pick.slot;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= vp_pkg::WR_IDLE;
            idx_q       <= '0;
            slot_cnt_q  <= '0;
            right_buf_q <= '0;
            left_buf_q  <= '0;
            right_rdy_q <= 1'b0;
            left_rdy_q  <= 1'b0;
        end else begin
            // readies are single-cycle pulses
            right_rdy_q <= 1'b0;
            left_rdy_q  <= 1'b0;
            if (!active) begin
                // scan starts next cycle, always on the right buffer
                if (i_start) begin
                    state_q <= vp_pkg::WR_RIGHT;
                end
            end else begin
                if (state_q == vp_pkg::WR_LEFT) begin
                    left_buf_q <= nxt_buf;
                    left_rdy_q <= buf_done;
                end else begin
                    right_buf_q <= nxt_buf;
                    right_rdy_q <= buf_done;
                end

                if (i_pick.at_end) begin
                    // flush done, back to idle
                    state_q    <= vp_pkg::WR_IDLE;
                    idx_q      <= '0;
                    slot_cnt_q <= '0;
                end else begin
                    idx_q <= idx_q + vp_pkg::IDX_W'(i_pick.step);
                    if (full) begin
                        slot_cnt_q <= '0;
                        // ping-pong to the other side
                        state_q    <= (state_q == vp_pkg::WR_LEFT) ? vp_pkg::WR_RIGHT
                                                                    : vp_pkg::WR_LEFT;
                    end else if (i_pick.found) begin
                        slot_cnt_q <= slot_cnt_q + 2'd1;
                    end
                end
            end
        end
    end

    assign o_idx         = idx_q;
    assign o_busy        = active;
    assign o_right_buf   = right_buf_q;
    assign o_left_buf    = left_buf_q;
    assign o_right_ready = right_rdy_q;
    assign o_left_ready  = left_rdy_q;

endmodule

/* verilog/vp_window_picker.sv */
// combinational only; expects i_len of at most 32 and stable entries while the scan runs
module vp_window_picker (
    input  logic [vp_pkg::IDX_W-1:0]      i_idx,
    input  logic [vp_pkg::IDX_W-1:0]      i_len,
    input  vp_pkg::entry_t                i_entries [vp_pkg::NUM_ENTRIES],
    input  logic signed [vp_pkg::DATA_W-1:0] i_ia_data [vp_pkg::NUM_CHANNELS],
    output vp_pkg::pick_t                 o_pick
);

    logic                         found;
    logic [1:0]                   step;
    logic [vp_pkg::IDX_W-1:0]     win_idx;
    logic [vp_pkg::ENT_SEL_W-1:0] hit_sel;
    vp_pkg::entry_t               hit_entry;

    // first valid entry wins, lower index first
    always_comb begin
        found   = 1'b0;
        step    = 2'(vp_pkg::WINDOW);
        hit_sel = '0;
        win_idx = i_idx;
        for (int k = 0; k < vp_pkg::WINDOW; k++) begin
            win_idx = i_idx + vp_pkg::IDX_W'(k);
            // past the length means empty
            if (!found && (win_idx < i_len) &&
                i_entries[win_idx[vp_pkg::ENT_SEL_W-1:0]].valid) begin
                found   = 1'b1;
                step    = 2'(k + 1);
                hit_sel = win_idx[vp_pkg::ENT_SEL_W-1:0];
            end
        end
    end

    assign hit_entry = i_entries[hit_sel];

    always_comb begin
        o_pick.at_end = (i_idx >= i_len);
        o_pick.found  = found;
        o_pick.step   = step;
        o_pick.slot   = '0;
        if (found) begin
            o_pick.slot.addr   = hit_entry.addr;
            o_pick.slot.weight = hit_entry.weight;
            // activation looked up by channel position
            o_pick.slot.act    = i_ia_data[hit_entry.pos];
        end
    end

endmodule

/* verilog/vp_cfg_regs.sv */
// no wait states; LEN writes above 32 are clamped to 32 and LEN and start are locked while busy
module vp_cfg_regs (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  vp_pkg::apb_req_t         i_apb,
    output vp_pkg::apb_rsp_t         o_apb,
    input  logic                     i_busy,
    output logic                     o_start,
    output logic [vp_pkg::IDX_W-1:0] o_len
);

    vp_pkg::reg_addr_e        addr;
    logic                     access;
    logic                     mapped;
    logic                     wr_ok;
    logic                     locked;
    logic [vp_pkg::IDX_W-1:0] len_q;
    logic                     start_q;

    assign addr   = vp_pkg::reg_addr_e'(i_apb.paddr);
    // transfer completes in the access phase
    assign access = i_apb.psel & i_apb.penable;
    assign mapped = (addr == vp_pkg::REG_CTRL) || (addr == vp_pkg::REG_LEN) ||
                    (addr == vp_pkg::REG_STATUS);
    // a pending start pulse counts as busy too
    assign locked = i_busy | start_q;
    assign wr_ok  = access & i_apb.pwrite & ~locked;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            len_q   <= '0;
            start_q <= 1'b0;
        end else begin
            // start is write-one, pulse lasts one cycle
            start_q <= wr_ok && (addr == vp_pkg::REG_CTRL) && i_apb.pwdata[0];
            if (wr_ok && (addr == vp_pkg::REG_LEN)) begin
                // keep the scan inside the entry list
                if (i_apb.pwdata > vp_pkg::APB_DATA_W'(vp_pkg::NUM_ENTRIES)) begin
                    len_q <= vp_pkg::IDX_W'(vp_pkg::NUM_ENTRIES);
                end else begin
                    len_q <= i_apb.pwdata[vp_pkg::IDX_W-1:0];
                end
            end
        end
    end

    // read mux, ctrl reads back as zero
    always_comb begin
        o_apb.prdata = '0;
        case (addr)
            vp_pkg::REG_LEN:    o_apb.prdata = vp_pkg::APB_DATA_W'(len_q);
            vp_pkg::REG_STATUS: o_apb.prdata = vp_pkg::APB_DATA_W'(i_busy);
            default:            o_apb.prdata = '0;
        endcase
    end

    assign o_apb.pready  = 1'b1;
    // unmapped offsets error out, nothing is written
    assign o_apb.pslverr = access & ~mapped;

    assign o_start = start_q;
    assign o_len   = len_q;

endmodule

/* verilog/vp_pkg.sv */
// sizes assume a list of at most 32 entries and 8 activation channels; APB data is 32 bits
package vp_pkg;

    // list and index sizing
    localparam int NUM_ENTRIES  = 32;
    localparam int IDX_W        = 6;
    localparam int ENT_SEL_W    = $clog2(NUM_ENTRIES);

    // activation vector
    localparam int NUM_CHANNELS = 8;
    localparam int POS_W        = 3;

    // address and data fields
    localparam int ADDR_FIELDS  = 3;
    localparam int ADDR_FIELD_W = 7;
    localparam int DATA_W       = 16;

    // scan window and output buffer
    localparam int WINDOW       = 3;
    localparam int SLOTS        = 3;

    // register bus
    localparam int APB_ADDR_W   = 4;
    localparam int APB_DATA_W   = 32;

    // one weight list entry
    typedef struct packed {
        logic                                     valid;
        logic [POS_W-1:0]                         pos;
        logic [ADDR_FIELDS-1:0][ADDR_FIELD_W-1:0] addr;
        logic signed [DATA_W-1:0]                 weight;
    } entry_t;

    // one packed output slot
    typedef struct packed {
        logic [ADDR_FIELDS-1:0][ADDR_FIELD_W-1:0] addr;
        logic signed [DATA_W-1:0]                 weight;
        logic signed [DATA_W-1:0]                 act;
    } slot_t;

    // slot 0 sits in the low bits
    typedef slot_t [SLOTS-1:0] pp_buf_t;

    // picker result for the current window
    typedef struct packed {
        logic       at_end;
        logic       found;
        logic [1:0] step;
        slot_t      slot;
    } pick_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_RIGHT,
        WR_LEFT
    } wr_state_e;

    typedef enum logic [APB_ADDR_W-1:0] {
        REG_CTRL   = 4'h0,
        REG_LEN    = 4'h4,
        REG_STATUS = 4'h8
    } reg_addr_e;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage
